/* design/sdramPkg.sv */
//////////////////////////////////////////////////////////////////////
// shared command, state and width types plus the timing constants
// for the SDR SDRAM power-up and refresh controller
//////////////////////////////////////////////////////////////////////
package sdramPkg;

	// chip pins packed as {cke, cs_l, ras_l, cas_l, we_l}
	typedef enum logic [4:0]
	{
		CmdPowerUp     = 5'b00000,	// cke and cs low while the chip powers up
		CmdNop         = 5'b10111,
		CmdPrecharge   = 5'b10010,	// all banks when addr[10] is high
		CmdAutoRefresh = 5'b10001,
		CmdModeSet     = 5'b10000,	// mode word rides on the address bus
		CmdDeselect    = 5'b11111
	} sdramCmd_t;

	// sequencer states, init path first then the idle/refresh loop
	typedef enum logic [4:0]
	{
		StInit, StWaitPowerUp, StFirstNop, StPrechargeAll, StPreNop,
		StRefresh, StRefreshNops, StModeSet, StModeNops, StLoadRefresh,
		StIdle, StRefPrecharge, StRefNop, StRefRefresh, StRefNops
	} ctrlState_t;

	typedef logic [12:0] rowAddr_t;		// 8192 rows, column uses the low 10 bits
	typedef logic [1:0]  bankAddr_t;	// 4 banks
	typedef logic [15:0] timerCount_t;

	//////////////////////////////////////////////////////////////////////
	// timing
	//////////////////////////////////////////////////////////////////////

	// short for simulation, 5000 gives 100 us at 50 MHz on real silicon
	localparam timerCount_t PowerUpCycles = 16'd20;

	localparam int unsigned InitRefreshCount = 8;	// auto-refreshes during init
	localparam int unsigned PostRefreshNops  = 4;	// tRC padding after each refresh
	localparam int unsigned PostModeNops     = 4;	// tMRD padding after mode set

	// idle cycles between refresh bursts, 7.5 us at 50 MHz
	localparam timerCount_t RefreshInterval = 16'd375;

	// mode word: write burst programmed, standard op, CL=2, sequential, BL=1
	localparam rowAddr_t ModeWord = 13'b000_0_00_010_0_000;

	localparam int unsigned PrechargeAllBit = 10;	// A10 selects all banks

endpackage

/* design/cycleTimer.sv */
//////////////////////////////////////////////////////////////////////
// loadable down-counter that parks at zero, used for power-up wait
// and for the refresh interval
//////////////////////////////////////////////////////////////////////
module cycleTimer import sdramPkg::*;
(
	input  logic        Clock,
	input  logic        Reset_L,
	input  logic        Load,		// load wins over counting
	input  timerCount_t LoadValue,
	output logic        Done		// high while count sits at zero
);

	timerCount_t count;

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
			count <= '0;
		else if (Load)
			count <= LoadValue;
		else if (count != '0)
			count <= count - 16'd1;	// stop once we hit zero
	end

	assign Done = (count == '0);

	// once expired and not reloaded, the count must hold at zero
	assertNoWrap: assert property (@(posedge Clock) disable iff (!Reset_L)
		(!Load && count == '0) |=> (count == '0))
		else $error("cycleTimer count wrapped below zero");

endmodule

/* design/initRefreshSeq.sv */
//////////////////////////////////////////////////////////////////////
// init and refresh state machine; picks command, address and bank
// each cycle and drives the two timers
//////////////////////////////////////////////////////////////////////
module initRefreshSeq import sdramPkg::*;
(
	input  logic        Clock,
	input  logic        Reset_L,
	input  logic        PowerUpDone,
	input  logic        RefreshDue,
	output logic        PowerUpLoad,
	output logic        RefreshLoad,
	output timerCount_t PowerUpValue,
	output timerCount_t RefreshValue,
	output sdramCmd_t   NextCmd,
	output rowAddr_t    NextAddr,
	output bankAddr_t   NextBank,
	output logic        CpuRelease
);

	ctrlState_t state;
	ctrlState_t nextState;
	logic [3:0] refreshCount;	// init auto-refreshes issued so far
	logic [3:0] nopCount;		// shared by every NOP run

	assign PowerUpValue = PowerUpCycles;
	assign RefreshValue = RefreshInterval;

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
			state <= StInit;
		else
			state <= nextState;
	end

	//////////////////////////////////////////////////////////////////////
	// counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			nopCount     <= '0;
			refreshCount <= '0;
		end
		else
		begin
			if (nextState != state)
				nopCount <= '0;		// fresh start for the next run
			else if (state inside {StRefreshNops, StModeNops, StRefNops})
				nopCount <= nopCount + 4'd1;

			if (state == StInit)
				refreshCount <= '0;
			else if (state == StRefresh)
				refreshCount <= refreshCount + 4'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and command
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState   = state;
		NextCmd     = CmdNop;	// most states just idle the bus
		NextAddr    = '0;
		NextBank    = '0;
		PowerUpLoad = 1'b0;
		RefreshLoad = 1'b0;
		CpuRelease  = 1'b0;		// processor held in reset until idle

		case (state)
			StInit:
			begin
				NextCmd     = CmdPowerUp;
				PowerUpLoad = 1'b1;		// start the power-up wait
				nextState   = StWaitPowerUp;
			end
			StWaitPowerUp:
			begin
				NextCmd = CmdPowerUp;
				if (PowerUpDone)
					nextState = StFirstNop;
			end
			StFirstNop:
				nextState = StPrechargeAll;
			StPrechargeAll:
			begin
				NextCmd                  = CmdPrecharge;
				NextAddr[PrechargeAllBit] = 1'b1;
				nextState                = StPreNop;
			end
			StPreNop:
				nextState = StRefresh;
			StRefresh:
			begin
				NextCmd   = CmdAutoRefresh;
				nextState = StRefreshNops;
			end
			StRefreshNops:
				if (nopCount == 4'(PostRefreshNops - 1))
				begin
					if (refreshCount == 4'(InitRefreshCount))
						nextState = StModeSet;
					else
						nextState = StRefresh;	// another init refresh
				end
			StModeSet:
			begin
				NextCmd   = CmdModeSet;
				NextAddr  = ModeWord;
				nextState = StModeNops;		// bank stays 0 for the base mode reg
			end
			StModeNops:
				if (nopCount == 4'(PostModeNops - 1))
					nextState = StLoadRefresh;
			StLoadRefresh:
			begin
				RefreshLoad = 1'b1;
				nextState   = StIdle;
			end
			StIdle:
			begin
				CpuRelease = 1'b1;
				if (RefreshDue)
					nextState = StRefPrecharge;
			end
			StRefPrecharge:
			begin
				CpuRelease               = 1'b1;
				NextCmd                  = CmdPrecharge;
				NextAddr[PrechargeAllBit] = 1'b1;
				nextState                = StRefNop;
			end
			StRefNop:
			begin
				CpuRelease = 1'b1;
				nextState  = StRefRefresh;
			end
			StRefRefresh:
			begin
				CpuRelease = 1'b1;
				NextCmd    = CmdAutoRefresh;
				nextState  = StRefNops;
			end
			StRefNops:
			begin
				CpuRelease = 1'b1;
				if (nopCount == 4'(PostRefreshNops - 1))
				begin
					RefreshLoad = 1'b1;	// rearm the interval on the way back
					nextState   = StIdle;
				end
			end
			default:
			begin
				NextCmd   = CmdDeselect;	// unreachable encoding, restart init
				nextState = StInit;
			end
		endcase
	end

	// never more init refreshes than asked for before mode set
	assertInitRefreshCount: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == StRefresh) |-> (refreshCount < 4'(InitRefreshCount)))
		else $error("too many init auto-refreshes");

	assertIdleExit: assert property (@(posedge Clock) disable iff (!Reset_L)
		(state == StIdle) |=> (state inside {StIdle, StRefPrecharge}))
		else $error("idle left for something other than refresh");

endmodule

/* design/sdramCmdDriver.sv */
//////////////////////////////////////////////////////////////////////
// registered pin stage, one cycle behind the sequencer, with checks
// on the pin-level rules
//////////////////////////////////////////////////////////////////////
module sdramCmdDriver import sdramPkg::*;
(
	input  logic      Clock,
	input  logic      Reset_L,
	input  logic      CpuRelease,
	input  sdramCmd_t NextCmd,
	input  rowAddr_t  NextAddr,
	input  bankAddr_t NextBank,
	output logic      SdramCke,
	output logic      SdramCs_L,
	output logic      SdramRas_L,
	output logic      SdramCas_L,
	output logic      SdramWe_L,
	output rowAddr_t  SdramAddr,
	output bankAddr_t SdramBa,
	output logic      ResetOut_L
);

	always_ff @(posedge Clock, negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			{SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L} <= CmdPowerUp;
			SdramAddr  <= '0;
			SdramBa    <= '0;
			ResetOut_L <= 1'b0;		// keep the processor in reset
		end
		else
		begin
			{SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L} <= NextCmd;
			SdramAddr  <= NextAddr;
			SdramBa    <= NextBank;
			ResetOut_L <= CpuRelease;
		end
	end

	assertCkeStays: assert property (@(posedge Clock) disable iff (!Reset_L)
		SdramCke |=> SdramCke)
		else $error("clock enable dropped after power-up");

	// controller only ever precharges all banks
	assertPrechargeAll: assert property (@(posedge Clock) disable iff (!Reset_L)
		({SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L} == CmdPrecharge)
		|-> SdramAddr[PrechargeAllBit])
		else $error("precharge without A10 high");

	assertReleaseStays: assert property (@(posedge Clock) disable iff (!Reset_L)
		ResetOut_L |=> ResetOut_L)
		else $error("processor reset reasserted without a reset");

endmodule

/* design/sdramInitRefreshCtrl.sv */
//////////////////////////////////////////////////////////////////////
// top level of the SDRAM init and refresh controller
//////////////////////////////////////////////////////////////////////
module sdramInitRefreshCtrl import sdramPkg::*;
(
	input  logic      Clock,
	input  logic      Reset_L,
	output logic      SdramCke,
	output logic      SdramCs_L,
	output logic      SdramRas_L,
	output logic      SdramCas_L,
	output logic      SdramWe_L,
	output rowAddr_t  SdramAddr,
	output bankAddr_t SdramBa,
	output logic      ResetOut_L
);

	logic        powerUpLoad;
	logic        powerUpDone;
	logic        refreshLoad;
	logic        refreshDue;
	timerCount_t powerUpValue;
	timerCount_t refreshValue;
	sdramCmd_t   nextCmd;
	rowAddr_t    nextAddr;
	bankAddr_t   nextBank;
	logic        cpuRelease;

	cycleTimer powerUpTimer (.Clock, .Reset_L, .Load(powerUpLoad),
		.LoadValue(powerUpValue), .Done(powerUpDone));

	cycleTimer refreshTimer (.Clock, .Reset_L, .Load(refreshLoad),
		.LoadValue(refreshValue), .Done(refreshDue));

	initRefreshSeq u_initRefreshSeq (.Clock, .Reset_L, .PowerUpDone(powerUpDone),
		.RefreshDue(refreshDue), .PowerUpLoad(powerUpLoad), .RefreshLoad(refreshLoad),
		.PowerUpValue(powerUpValue), .RefreshValue(refreshValue), .NextCmd(nextCmd),
		.NextAddr(nextAddr), .NextBank(nextBank), .CpuRelease(cpuRelease));

	sdramCmdDriver u_sdramCmdDriver (.Clock, .Reset_L, .CpuRelease(cpuRelease),
		.NextCmd(nextCmd), .NextAddr(nextAddr), .NextBank(nextBank),
		.SdramCke, .SdramCs_L, .SdramRas_L, .SdramCas_L, .SdramWe_L,
		.SdramAddr, .SdramBa, .ResetOut_L);

endmodule

/* sim/sdramCtrlTb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the SDRAM init and refresh controller, replays the
// command events in sim/sdramCtrl_stim.txt and checks the chip pins
//////////////////////////////////////////////////////////////////////
module sdramCtrlTb;

	// NOP on {cke, cs_l, ras_l, cas_l, we_l} per the SDR truth table
	localparam logic [4:0] NopPins = 5'b10111;
	localparam int         Fields  = 7;		// numbers kept per stimulus line

	logic        Clock;
	logic        Reset_L;
	logic        SdramCke;
	logic        SdramCs_L;
	logic        SdramRas_L;
	logic        SdramCas_L;
	logic        SdramWe_L;
	logic [12:0] SdramAddr;
	logic [1:0]  SdramBa;
	logic        ResetOut_L;

	byte         kindQ[$];		// R, E or U per stimulus line
	int          argQ[$];		// Fields numbers per line, zero padded
	logic [4:0]  curPins;		// latest sample, not yet consumed
	logic [12:0] curAddr;
	logic [1:0]  curBank;
	logic        curRelease;
	logic        released;		// level ResetOut_L must show now
	int          cycleCount;
	int          cycleLimit;
	int          resetCount;

	sdramInitRefreshCtrl u_sdramInitRefreshCtrl (.Clock, .Reset_L, .SdramCke, .SdramCs_L,
		.SdramRas_L, .SdramCas_L, .SdramWe_L, .SdramAddr, .SdramBa, .ResetOut_L);

	always #20 Clock = ~Clock;	// period 40

	//////////////////////////////////////////////////////////////////////
	// error reporting and sampling
	//////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string reason);
		$display("ERROR: %s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string test, input string what, input int expected,
		input int actual);
		$display("[FAIL] %s: %s expected %0h actual %0h", test, what, expected, actual);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic reportWindow(input string test, input string what, input int minV,
		input int maxV, input int actual);
		$display("[FAIL] %s: %s expected %0d..%0d actual %0d", test, what, minV, maxV, actual);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// pins settle half a cycle after the rising edge
	task automatic nextCycle();
		@(negedge Clock);
		curPins    = {SdramCke, SdramCs_L, SdramRas_L, SdramCas_L, SdramWe_L};
		curAddr    = SdramAddr;
		curBank    = SdramBa;
		curRelease = ResetOut_L;
		cycleCount++;
		assert (cycleCount <= cycleLimit)
		else abortRun($sformatf("timeout, no expected event within %0d cycles", cycleLimit));
	endtask

	task automatic checkRelease(input string test);
		assert (curRelease === released)
		else reportMismatch(test, "ResetOut_L", int'(released), int'(curRelease));
	endtask

	task automatic checkPowerUp(input string test);
		assert (curPins[4] === 1'b0 && curPins[3] === 1'b0)	// cke and cs_l both low
		else reportMismatch(test, "cke and cs_l", 0, int'(curPins[4:3]));
		assert (curRelease === 1'b0)
		else reportMismatch(test, "ResetOut_L", 0, int'(curRelease));
	endtask

	function automatic string eventTestName();
		if (released)
			return "periodic refresh";
		else if (resetCount > 1)
			return "mid-run reset";
		else
			return "init order";
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus line handlers
	//////////////////////////////////////////////////////////////////////

	task automatic applyReset(input int delay, input int cycles, input int minPu, input int maxPu);
		int puLen;
		puLen = 0;
		repeat (delay)	// idle NOPs before the pulse lands
		begin
			assert (curPins === NopPins)
			else reportMismatch("mid-run reset", "idle command", int'(NopPins), int'(curPins));
			checkRelease("mid-run reset");
			nextCycle();
		end
		Reset_L  = 1'b0;
		released = 1'b0;
		resetCount++;
		repeat (cycles)
		begin
			nextCycle();
			checkPowerUp("reset state");
		end
		Reset_L = 1'b1;
		nextCycle();
		while (curPins[4] === 1'b0)		// cke low, still powering up
		begin
			checkPowerUp("reset state");
			puLen++;
			nextCycle();
		end
		assert (puLen >= minPu && puLen <= maxPu)
		else reportWindow("reset state", "power-up cycles", minPu, maxPu, puLen);
	endtask

	// skip NOPs, then the next command must be the expected one
	task automatic matchEvent(input int cmd, input int addr, input int mask, input int bank,
		input int minGap, input int maxGap);
		int    gap;
		string test;
		gap  = 0;
		test = eventTestName();
		while (curPins === NopPins)
		begin
			checkRelease(test);
			gap++;
			nextCycle();
		end
		checkRelease(test);
		assert (curPins === cmd[4:0])
		else reportMismatch(test, "command", cmd, int'(curPins));
		assert (gap >= minGap && gap <= maxGap)
		else reportWindow(test, "NOP gap", minGap, maxGap, gap);
		assert ((curAddr & mask[12:0]) === addr[12:0])
		else reportMismatch(test, "address", addr, int'(curAddr & mask[12:0]));
		assert (curBank === bank[1:0])
		else reportMismatch(test, "bank", bank, int'(curBank));
		nextCycle();
	endtask

	// NOPs with the processor still in reset, then release on an idle NOP
	task automatic waitRelease(input int minGap, input int maxGap);
		int gap;
		gap = 0;
		while (curPins === NopPins && curRelease === 1'b0)
		begin
			gap++;
			nextCycle();
		end
		assert (curPins === NopPins)
		else reportMismatch("processor release", "first idle command", int'(NopPins),
			int'(curPins));
		assert (curRelease === 1'b1)
		else reportMismatch("processor release", "ResetOut_L", 1, int'(curRelease));
		assert (gap >= minGap && gap <= maxGap)
		else reportWindow("processor release", "NOPs before release", minGap, maxGap, gap);
		released = 1'b1;	// first idle sample stays unconsumed for the next gap
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus file
	//////////////////////////////////////////////////////////////////////

	task automatic loadStimulus();
		int    fd;
		int    n;
		int    f[Fields];
		string line;
		string rest;
		fd = $fopen("sim/sdramCtrl_stim.txt", "r");
		assert (fd != 0)
		else abortRun("cannot open sim/sdramCtrl_stim.txt");
		while ($fgets(line, fd) > 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;			// blank or column notes
			for (int j = 0; j < Fields; j++)
				f[j] = 0;
			rest = line.substr(1, line.len() - 1);
			case (line[0])
				"E": n = $sscanf(rest, "%h %h %h %d %d %d %d", f[0], f[1], f[2], f[3], f[4],
					f[5], f[6]) - 7;
				"R": n = $sscanf(rest, "%d %d %d %d", f[0], f[1], f[2], f[3]) - 4;
				"U": n = $sscanf(rest, "%d %d", f[0], f[1]) - 2;
				default: n = -1;
			endcase
			assert (n == 0)
			else abortRun({"malformed stimulus line: ", line});
			kindQ.push_back(line[0]);
			for (int j = 0; j < Fields; j++)
				argQ.push_back(f[j]);
		end
		$fclose(fd);
	endtask

	// worst case cycles over the whole file
	function automatic int stimulusBudget();
		int sum;
		int base;
		sum = 0;
		for (int i = 0; i < kindQ.size(); i++)
		begin
			base = i * Fields;
			case (kindQ[i])
				"R": sum += argQ[base] + argQ[base + 1] + argQ[base + 3];
				"U": sum += argQ[base + 1] + 1;
				default: sum += (argQ[base + 5] + 1) * argQ[base + 6];
			endcase
		end
		return sum;
	endfunction

	initial
	begin
		int base;
		Clock      = 1'b0;
		Reset_L    = 1'b0;
		released   = 1'b0;
		cycleCount = 0;
		resetCount = 0;
		curPins    = '0;
		curAddr    = '0;
		curBank    = '0;
		curRelease = 1'b0;
		loadStimulus();
		cycleLimit = 2 * stimulusBudget();
		for (int i = 0; i < kindQ.size(); i++)
		begin
			base = i * Fields;
			case (kindQ[i])
				"R": applyReset(argQ[base], argQ[base + 1], argQ[base + 2], argQ[base + 3]);
				"U": waitRelease(argQ[base], argQ[base + 1]);
				default:
					repeat (argQ[base + 6])
						matchEvent(argQ[base], argQ[base + 1], argQ[base + 2], argQ[base + 3],
							argQ[base + 4], argQ[base + 5]);
			endcase
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* sim/sdramCtrl_stim.txt */
# R: idle NOPs before the pulse, reset cycles, min and max power-up cycles
# E: pins {cke,cs_l,ras_l,cas_l,we_l} hex, addr hex, addr mask hex, bank,
#    min and max NOPs before it, repeat count
# U: min and max NOPs with ResetOut_L still low before release
# power-up and initialisation
R 0 8 20 23
E 12 0400 0400 0 1 1 1
E 11 0000 0000 0 1 1 1
E 11 0000 0000 0 4 4 7
E 10 0020 1fff 0 4 4 1
U 5 5
# three refresh bursts: precharge, NOP, auto-refresh
E 12 0400 0400 0 375 377 1
E 11 0000 0000 0 1 1 1
E 12 0400 0400 0 379 381 1
E 11 0000 0000 0 1 1 1
E 12 0400 0400 0 379 381 1
E 11 0000 0000 0 1 1 1
# reset during idle, then the whole initialisation again
R 10 8 20 23
E 12 0400 0400 0 1 1 1
E 11 0000 0000 0 1 1 1
E 11 0000 0000 0 4 4 7
E 10 0020 1fff 0 4 4 1
U 5 5
# idle resumes refreshing
E 12 0400 0400 0 375 377 1
E 11 0000 0000 0 1 1 1

/* sim.f */
design/sdramPkg.sv
design/cycleTimer.sv
design/initRefreshSeq.sv
design/sdramCmdDriver.sv
design/sdramInitRefreshCtrl.sv
sim/sdramCtrlTb.sv

/* run.sh */
#!/bin/sh
# build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module sdramCtrlTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "run ended without a result"
	exit 1
fi
